//--- common/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

   localparam int unsigned SDRAM_ADDR_W  = 25;
   localparam int unsigned ROM_OFFSET_W  = 14;               // 16 KB per slot
   localparam int unsigned ROM_DEPTH     = 2 ** ROM_OFFSET_W;
   localparam int unsigned NUM_ROM_SLOTS = 3;

   // on-chip slot order
   localparam logic [1:0] SLOT_OS    = 2'd0;
   localparam logic [1:0] SLOT_BASIC = 2'd1;
   localparam logic [1:0] SLOT_SMMC  = 2'd2;

   // romsel banks, high and low mapping
   localparam logic [3:0] BASIC_BANK_HIGH = 4'hE;
   localparam logic [3:0] BASIC_BANK_LOW  = 4'h0;
   localparam logic [3:0] SMMC_BANK_HIGH  = 4'hC;
   localparam logic [3:0] SMMC_BANK_LOW   = 4'h2;
   localparam logic [3:0] RAM_BANK        = 4'hA;   // rom image kept in sdram

   localparam logic [1:0] REGION_SIDEWAYS     = 2'b10;   // 8000-bfff
   localparam logic [1:0] REGION_OS           = 2'b11;   // c000-ffff
   localparam logic [1:0] SIDEWAYS_RAM_PREFIX = 2'b01;   // banks 4 to 7
   localparam logic [6:0] SIDEWAYS_SDRAM_BASE = 7'b0000001;

   localparam int unsigned LOADER_ROM_FLAG_BIT = 24;
   localparam logic [7:0]  UNMAPPED_BYTE       = 8'hFF;

   // the same 16 bit address seen as ram offset or as region plus rom offset
   typedef union packed {
      struct packed {
         logic        top;
         logic [14:0] offset;
      } ram;
      struct packed {
         logic [1:0]  region;
         logic [13:0] offset;
      } rom;
   } cpu_addr_u;

   typedef struct packed {
      logic [SDRAM_ADDR_W-1:0] addr;
      logic                    we;
      logic [7:0]              wdata;
   } sdram_req_t;

   typedef struct packed {
      logic       ram;        // main ram byte
      logic       sdram;      // sideways bank byte
      logic       rom;        // on-chip slot
      logic       unmapped;
      logic [1:0] slot;
   } read_route_t;

   localparam read_route_t ROUTE_UNMAPPED = '{
      ram: 1'b0, sdram: 1'b0, rom: 1'b0, unmapped: 1'b1, slot: 2'd0
   };

   typedef struct packed {
      cpu_addr_u  addr;
      logic [3:0] romsel;
      logic       we;
      logic [7:0] wdata;
   } cpu_access_t;

   typedef struct packed {
      logic                    active;
      logic                    we;
      logic [SDRAM_ADDR_W-1:0] addr;   // bit 24 flags an on-chip rom write
      logic [7:0]              data;
   } loader_write_t;

endpackage

`default_nettype wire

//--- common/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

   // status byte from the osd menu
   typedef struct packed {
      logic [2:0] spare;
      logic       reset_toggle;   // reset entry of the menu
      logic       autoboot;
      logic       rom_map_low;    // 1 = low rom mapping
      logic       scanlines;      // only used by the video side
      logic       menu_reset;     // io controller boot
   } menu_status_t;

   typedef struct packed {
      logic core_reset;
      logic autoboot_shift;   // shift key pressed on the keyboard matrix
   } core_ctrl_t;

   // about 128 us at 32 MHz after a mapping change
   localparam int unsigned REMAP_HOLD_CYCLES = 4095;
   localparam int unsigned REMAP_CNT_W       = $clog2(REMAP_HOLD_CYCLES + 1);

endpackage

`default_nettype wire

//--- mem_map/mem_map_decode.sv
`default_nettype none

module mem_map_decode (
   input  logic                                 clk_32m,
   input  logic                                 reset,
   input  mem_map_pkg::cpu_access_t             cpu,
   input  logic                                 mem_sync,
   input  mem_map_pkg::loader_write_t           loader,
   input  logic                                 rom_map_low,
   output mem_map_pkg::sdram_req_t              sdram_req,
   output mem_map_pkg::read_route_t             route,
   output logic [mem_map_pkg::ROM_OFFSET_W-1:0] rd_offset,
   output logic [mem_map_pkg::ROM_OFFSET_W-1:0] wr_offset,
   output logic [7:0]                           wr_data,
   output logic [mem_map_pkg::NUM_ROM_SLOTS-1:0] slot_we
);
   import mem_map_pkg::*;

   logic [3:0]               basic_bank;
   logic [3:0]               smmc_bank;
   logic                     cpu_ram;
   logic                     sideways_ram;
   read_route_t              route_d;
   sdram_req_t               cpu_req;
   sdram_req_t               loader_req;
   logic                     loader_rom;
   logic [1:0]               loader_slot;
   logic [NUM_ROM_SLOTS-1:0] slot_we_d;
   logic                     req_we;
   logic [SDRAM_ADDR_W-1:0]  req_addr;
   logic [7:0]               req_wdata;

   assign basic_bank   = rom_map_low ? BASIC_BANK_LOW : BASIC_BANK_HIGH;
   assign smmc_bank    = rom_map_low ? SMMC_BANK_LOW : SMMC_BANK_HIGH;
   assign cpu_ram      = ~cpu.addr.ram.top;
   assign sideways_ram = (cpu.addr.rom.region == REGION_SIDEWAYS) &&
                         (cpu.romsel[3:2] == SIDEWAYS_RAM_PREFIX);

   // read route, bank checks in priority order
   always_comb begin
      route_d = ROUTE_UNMAPPED;
      if (cpu_ram) begin
         route_d = '{ram: 1'b1, sdram: 1'b0, rom: 1'b0, unmapped: 1'b0, slot: 2'd0};
      end else if (cpu.addr.rom.region == REGION_OS) begin
         route_d = '{ram: 1'b0, sdram: 1'b0, rom: 1'b1, unmapped: 1'b0, slot: SLOT_OS};
      end else if (cpu.romsel == basic_bank) begin
         route_d = '{ram: 1'b0, sdram: 1'b0, rom: 1'b1, unmapped: 1'b0, slot: SLOT_BASIC};
      end else if (cpu.romsel == smmc_bank) begin
         route_d = '{ram: 1'b0, sdram: 1'b0, rom: 1'b1, unmapped: 1'b0, slot: SLOT_SMMC};
      end else if ((cpu.romsel == RAM_BANK) || sideways_ram) begin
         route_d = '{ram: 1'b0, sdram: 1'b1, rom: 1'b0, unmapped: 1'b0, slot: 2'd0};
      end
   end

   assign cpu_req.addr  = cpu_ram ? {{(SDRAM_ADDR_W - 16){1'b0}}, cpu.addr}
                                  : {SIDEWAYS_SDRAM_BASE, cpu.romsel, cpu.addr.rom.offset};
   assign cpu_req.we    = cpu.we && (cpu_ram || sideways_ram);
   assign cpu_req.wdata = cpu.wdata;

   // rom flagged loader writes stay off the sdram
   assign loader_rom       = loader.addr[LOADER_ROM_FLAG_BIT];
   assign loader_slot      = loader.addr[ROM_OFFSET_W+1:ROM_OFFSET_W];
   assign loader_req.addr  = loader.addr;
   assign loader_req.we    = loader.we && !loader_rom;
   assign loader_req.wdata = loader.data;

   always_comb begin
      slot_we_d = '0;
      if (loader.active && loader.we && loader_rom && (loader_slot < NUM_ROM_SLOTS))
         slot_we_d[loader_slot] = 1'b1;   // slot 3 dropped
   end

   always_ff @(posedge clk_32m) begin
      if (reset) begin
         req_we  <= 1'b0;
         route   <= ROUTE_UNMAPPED;
         slot_we <= '0;
      end else begin
         slot_we <= slot_we_d;
         if (loader.active)
            req_we <= loader_req.we;   // loader owns sdram every edge
         else if (mem_sync)
            req_we <= cpu_req.we;
         if (mem_sync)
            route <= route_d;
      end
   end

   always_ff @(posedge clk_32m) begin
      wr_offset <= loader.addr[ROM_OFFSET_W-1:0];
      wr_data   <= loader.data;
      if (mem_sync)
         rd_offset <= cpu.addr.rom.offset;
      if (loader.active) begin
         req_addr  <= loader_req.addr;
         req_wdata <= loader_req.wdata;
      end else if (mem_sync) begin
         req_addr  <= cpu_req.addr;
         req_wdata <= cpu_req.wdata;
      end
   end

   assign sdram_req = '{addr: req_addr, we: req_we, wdata: req_wdata};

   // at most one slot written, and only from a loader cycle
   a_slot_we_onehot: assert property (@(posedge clk_32m) disable iff (reset)
      $onehot0(slot_we) && ((slot_we == '0) || $past(loader.active)));

endmodule

`default_nettype wire

//--- mem_map/rom_slot.sv
`default_nettype none

module rom_slot (
   input  logic                                 clk_32m,
   input  logic                                 we,
   input  logic [mem_map_pkg::ROM_OFFSET_W-1:0] wr_offset,
   input  logic [7:0]                           wr_data,
   input  logic [mem_map_pkg::ROM_OFFSET_W-1:0] rd_offset,
   output logic [7:0]                           rd_data
);
   import mem_map_pkg::*;

   logic [7:0] image [ROM_DEPTH];   // one 16 KB rom, maps to block ram

   // loader side
   always_ff @(posedge clk_32m) begin
      if (we)
         image[wr_offset] <= wr_data;
   end

   // cpu side, one cycle read latency
   always_ff @(posedge clk_32m) begin
      rd_data <= image[rd_offset];
   end

endmodule

`default_nettype wire

//--- mem_map/read_data_select.sv
`default_nettype none

module read_data_select (
   input  logic                                        clk_32m,
   input  logic                                        reset,
   input  mem_map_pkg::read_route_t                    route,
   input  logic [mem_map_pkg::NUM_ROM_SLOTS-1:0][7:0]  slot_data,
   input  logic [7:0]                                  ram_do,
   output logic [7:0]                                  mem_di
);
   import mem_map_pkg::*;

   read_route_t route_q;    // lines up with slot read data
   logic [7:0]  sel_byte;

   always_ff @(posedge clk_32m) begin
      if (reset)
         route_q <= ROUTE_UNMAPPED;
      else
         route_q <= route;
   end

   always_comb begin
      if (route_q.ram || route_q.sdram)
         sel_byte = ram_do;    // both come back from the sdram
      else if (route_q.rom && (route_q.slot < NUM_ROM_SLOTS))
         sel_byte = slot_data[route_q.slot];
      else
         sel_byte = UNMAPPED_BYTE;
   end

   always_ff @(posedge clk_32m) begin
      if (reset)
         mem_di <= UNMAPPED_BYTE;
      else
         mem_di <= sel_byte;
   end

   // decoder always names exactly one source, and rom routes a real slot
   a_route_onehot: assert property (@(posedge clk_32m) disable iff (reset)
      $onehot({route.ram, route.sdram, route.rom, route.unmapped}) &&
      (!route.rom || (route.slot < NUM_ROM_SLOTS)));

endmodule

`default_nettype wire

//--- src/reset_control.sv
`default_nettype none

module reset_control #(
   parameter int unsigned AUTOBOOT_CYCLES = 32000000
) (
   input  logic                        clk_32m,
   input  logic                        reset,
   input  core_ctrl_pkg::menu_status_t status,
   input  logic                        button,
   input  logic                        pll_ready,
   input  logic                        sdram_ready,
   input  logic                        loader_active,
   output core_ctrl_pkg::core_ctrl_t   ctrl
);
   import core_ctrl_pkg::*;

   localparam int unsigned BOOT_CNT_W = $clog2(AUTOBOOT_CYCLES + 1);

   logic                   last_rom_map;
   logic [REMAP_CNT_W-1:0] remap_cnt;
   logic                   remap_hold;
   logic                   reset_in;
   logic                   core_reset_q;
   logic [BOOT_CNT_W-1:0]  boot_cnt;

   // rom mapping change restarts the core with the new banks
   always_ff @(posedge clk_32m) begin
      last_rom_map <= status.rom_map_low;
      if (reset)
         remap_cnt <= '0;
      else if (last_rom_map != status.rom_map_low)
         remap_cnt <= REMAP_CNT_W'(REMAP_HOLD_CYCLES);
      else if (remap_cnt != '0)
         remap_cnt <= remap_cnt - 1'b1;
   end

   assign remap_hold = (remap_cnt != '0) || (last_rom_map != status.rom_map_low);

   // pll, sdram, menu, button, loader and remap all restart the core
   assign reset_in = ~pll_ready || ~sdram_ready || status.menu_reset ||
                     status.reset_toggle || button || loader_active || remap_hold;

   always_ff @(posedge clk_32m) begin
      if (reset)
         core_reset_q <= 1'b1;
      else
         core_reset_q <= reset_in;
   end

   // shift held after each core reset so the os boots from disc
   always_ff @(posedge clk_32m) begin
      if (reset)
         boot_cnt <= '0;
      else if (core_reset_q)
         boot_cnt <= BOOT_CNT_W'(AUTOBOOT_CYCLES);
      else if (boot_cnt != '0)
         boot_cnt <= boot_cnt - 1'b1;
   end

   assign ctrl = '{
      core_reset:     core_reset_q,
      autoboot_shift: status.autoboot && (boot_cnt != '0) && !core_reset_q
   };

   // full boot key time is loaded as the core leaves reset
   a_boot_cnt_loaded: assert property (@(posedge clk_32m) disable iff (reset)
      $fell(core_reset_q) |-> (boot_cnt == BOOT_CNT_W'(AUTOBOOT_CYCLES)));

endmodule

`default_nettype wire

//--- src/bbc_mem_subsystem.sv
`default_nettype none

module bbc_mem_subsystem #(
   parameter int unsigned AUTOBOOT_CYCLES = 32000000
) (
   input  logic                        clk_32m,
   input  logic                        reset,
   input  mem_map_pkg::cpu_access_t    cpu,
   input  logic                        mem_sync,
   input  mem_map_pkg::loader_write_t  loader,
   input  core_ctrl_pkg::menu_status_t status,
   input  logic                        button,
   input  logic                        pll_ready,
   input  logic                        sdram_ready,
   input  logic [7:0]                  ram_do,
   output mem_map_pkg::sdram_req_t     sdram_req,
   output logic [7:0]                  mem_di,
   output core_ctrl_pkg::core_ctrl_t   ctrl
);
   import mem_map_pkg::*;

   read_route_t                   route;
   logic [ROM_OFFSET_W-1:0]       rd_offset;
   logic [ROM_OFFSET_W-1:0]       wr_offset;
   logic [7:0]                    wr_data;
   logic [NUM_ROM_SLOTS-1:0]      slot_we;
   logic [NUM_ROM_SLOTS-1:0][7:0] slot_data;

   mem_map_decode u_decode (
      .clk_32m     (clk_32m),
      .reset       (reset),
      .cpu         (cpu),
      .mem_sync    (mem_sync),
      .loader      (loader),
      .rom_map_low (status.rom_map_low),
      .sdram_req   (sdram_req),
      .route       (route),
      .rd_offset   (rd_offset),
      .wr_offset   (wr_offset),
      .wr_data     (wr_data),
      .slot_we     (slot_we)
   );

   // os, basic and smmc images
   for (genvar i = 0; i < NUM_ROM_SLOTS; i++) begin : g_slot
      rom_slot u_slot (
         .clk_32m   (clk_32m),
         .we        (slot_we[i]),
         .wr_offset (wr_offset),
         .wr_data   (wr_data),
         .rd_offset (rd_offset),
         .rd_data   (slot_data[i])
      );
   end

   read_data_select u_select (
      .clk_32m   (clk_32m),
      .reset     (reset),
      .route     (route),
      .slot_data (slot_data),
      .ram_do    (ram_do),
      .mem_di    (mem_di)
   );

   reset_control #(
      .AUTOBOOT_CYCLES (AUTOBOOT_CYCLES)
   ) u_reset_ctrl (
      .clk_32m       (clk_32m),
      .reset         (reset),
      .status        (status),
      .button        (button),
      .pll_ready     (pll_ready),
      .sdram_ready   (sdram_ready),
      .loader_active (loader.active),
      .ctrl          (ctrl)
   );

endmodule

`default_nettype wire

//--- test/tb_bbc_mem_subsystem.sv
`default_nettype none

module tb_bbc_mem_subsystem;
   timeunit 1ns;
   timeprecision 1ps;

   import mem_map_pkg::*;
   import core_ctrl_pkg::*;

   localparam int unsigned AUTOBOOT_CYCLES = 200;

   logic          clk_32m = 1'b0;
   logic          reset;
   cpu_access_t   cpu;
   logic          mem_sync;
   loader_write_t loader;
   menu_status_t  status;
   logic          button;
   logic          pll_ready;
   logic          sdram_ready;
   logic [7:0]    ram_do = 8'h00;
   sdram_req_t    sdram_req;
   logic [7:0]    mem_di;
   core_ctrl_t    ctrl;

   logic [7:0]    sdram_mem [logic [24:0]];   // bytes written into external sdram
   string         lines[$];
   string         line;
   string         name;
   int            fd;
   int            n;
   int            cycle_count = 0;
   int            cycle_limit = 0;
   logic [7:0]    op;
   logic [31:0]   v1, v2, v3, v4, v5, v6;
   sdram_req_t    exp_req;

   bbc_mem_subsystem #(
      .AUTOBOOT_CYCLES (AUTOBOOT_CYCLES)
   ) DUT (
      .clk_32m     (clk_32m),
      .reset       (reset),
      .cpu         (cpu),
      .mem_sync    (mem_sync),
      .loader      (loader),
      .status      (status),
      .button      (button),
      .pll_ready   (pll_ready),
      .sdram_ready (sdram_ready),
      .ram_do      (ram_do),
      .sdram_req   (sdram_req),
      .mem_di      (mem_di),
      .ctrl        (ctrl)
   );

   always #20 clk_32m = ~clk_32m;   // 25 MHz stand-in for the 32 MHz clock

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   always @(posedge clk_32m) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit)
         stop_on_error($sformatf("timeout, run passed its limit of %0d cycles", cycle_limit));
   end

   // unwritten sdram reads a pattern folded from every address bit
   function automatic logic [7:0] sdram_byte(input logic [24:0] a);
      if (sdram_mem.exists(a))
         return sdram_mem[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]} ^ 8'hC3;
   endfunction

   // sdram model, request seen after the edge and data back before E2
   always @(negedge clk_32m) begin
      if (sdram_req.we === 1'b1)
         sdram_mem[sdram_req.addr] = sdram_req.wdata;
      ram_do <= sdram_byte(sdram_req.addr);
   end

   task automatic check_byte(input string tname, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         stop_on_error($sformatf("** Error %s: expected %h, actual %h", tname, exp, act));
   endtask

   task automatic check_sdram_req(input string tname, input sdram_req_t exp,
                                  input sdram_req_t act);
      if (act !== exp)
         stop_on_error($sformatf("** Error %s: expected addr %h we %b wdata %h, actual addr %h we %b wdata %h",
                                 tname, exp.addr, exp.we, exp.wdata, act.addr, act.we, act.wdata));
   endtask

   task automatic check_ctrl(input string tname, input core_ctrl_t exp, input core_ctrl_t act);
      if (act !== exp)
         stop_on_error($sformatf("** Error %s: expected reset %b shift %b, actual reset %b shift %b",
                                 tname, exp.core_reset, exp.autoboot_shift,
                                 act.core_reset, act.autoboot_shift));
   endtask

   task automatic check_cycles(input string tname, input int exp, input int act);
      if (act != exp)
         stop_on_error($sformatf("** Error %s: expected %0d cycles, actual %0d", tname, exp, act));
   endtask

   task automatic wait_core_reset_low();
      while (ctrl.core_reset !== 1'b0)
         @(negedge clk_32m);
   endtask

   // loader stays active until a line of another kind comes
   task automatic loader_write(input string tname, input logic [24:0] addr, input logic [7:0] data);
      loader   = loader_write_t'{active: 1'b1, we: 1'b1, addr: addr, data: data};
      mem_sync = 1'b0;
      @(posedge clk_32m);
      @(negedge clk_32m);
      check_sdram_req(tname, sdram_req_t'{addr: addr, we: !addr[LOADER_ROM_FLAG_BIT], wdata: data},
                      sdram_req);
   endtask

   task automatic cpu_access(input string tname, input logic we, input logic [15:0] addr,
                             input logic [3:0] romsel, input logic [7:0] wdata,
                             input sdram_req_t exp, input logic [7:0] exp_byte);
      cpu.addr   = addr;
      cpu.romsel = romsel;
      cpu.we     = we;
      cpu.wdata  = wdata;
      mem_sync   = 1'b1;
      @(posedge clk_32m);   // E0
      @(negedge clk_32m);
      mem_sync = 1'b0;
      cpu.we   = 1'b0;
      check_sdram_req({tname, " sdram_req"}, exp, sdram_req);
      repeat (2) @(posedge clk_32m);   // E1 slot read, E2 byte select
      @(negedge clk_32m);
      check_byte({tname, " mem_di"}, exp_byte, mem_di);
   endtask

   task automatic apply_status(input string tname, input menu_status_t new_status);
      logic changed;
      int   held;
      changed = new_status.rom_map_low != status.rom_map_low;
      held    = 0;
      wait_core_reset_low();
      status = new_status;
      @(negedge clk_32m);
      if (changed) begin
         while (ctrl.core_reset === 1'b1) begin
            held++;
            @(negedge clk_32m);
         end
         // edge detect cycle plus the hold count
         check_cycles({tname, " remap hold"}, int'(REMAP_HOLD_CYCLES) + 1, held);
      end
   endtask

   task automatic pulse_reset_source(input string tname, input int source);
      wait_core_reset_low();
      case (source)
         0: button = 1'b1;
         1: pll_ready = 1'b0;
         2: sdram_ready = 1'b0;
         3: status.menu_reset = 1'b1;
         4: status.reset_toggle = 1'b1;
         5: loader.active = 1'b1;
         default: stop_on_error($sformatf("%s names unknown reset source %0d", tname, source));
      endcase
      @(posedge clk_32m);
      @(negedge clk_32m);
      check_ctrl(tname, core_ctrl_t'{core_reset: 1'b1, autoboot_shift: 1'b0}, ctrl);
      button              = 1'b0;
      pll_ready           = 1'b1;
      sdram_ready         = 1'b1;
      status.menu_reset   = 1'b0;
      status.reset_toggle = 1'b0;
      loader.active       = 1'b0;
   endtask

   task automatic check_autoboot(input string tname);
      int held;
      held = 0;
      wait_core_reset_low();
      button = 1'b1;
      @(posedge clk_32m);
      @(negedge clk_32m);
      button = 1'b0;
      wait_core_reset_low();
      check_ctrl({tname, " shift on"}, core_ctrl_t'{core_reset: 1'b0, autoboot_shift: 1'b1}, ctrl);
      while (ctrl.autoboot_shift === 1'b1) begin
         held++;
         @(negedge clk_32m);
      end
      check_cycles({tname, " shift time"}, int'(AUTOBOOT_CYCLES), held);
      check_ctrl({tname, " shift off"}, core_ctrl_t'{core_reset: 1'b0, autoboot_shift: 1'b0}, ctrl);
   endtask

   initial begin
      reset       = 1'b1;
      cpu         = '0;
      mem_sync    = 1'b0;
      loader      = '0;
      status      = '0;   // high rom mapping
      button      = 1'b0;
      pll_ready   = 1'b1;
      sdram_ready = 1'b1;

      fd = $fopen("test/bbc_mem_input.txt", "r");
      if (fd == 0)
         stop_on_error("could not open the stimulus file test/bbc_mem_input.txt");
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         if (line.len() > 1 && line.getc(0) != "#")
            lines.push_back(line);
      end
      $fclose(fd);
      cycle_limit = lines.size() * 8 + int'(REMAP_HOLD_CYCLES) + int'(AUTOBOOT_CYCLES) + 100;

      repeat (10) @(posedge clk_32m);
      @(negedge clk_32m);
      check_byte("reset mem_di", 8'hFF, mem_di);
      check_ctrl("reset ctrl", core_ctrl_t'{core_reset: 1'b1, autoboot_shift: 1'b0}, ctrl);
      reset = 1'b0;

      for (int i = 0; i < lines.size(); i++) begin
         n    = $sscanf(lines[i], "%c %h %h %h %h %h %h", op, v1, v2, v3, v4, v5, v6);
         name = $sformatf("step %0d %c", i + 1, op);
         if (op != "L")
            loader = '0;
         case (op)
            "L": loader_write(name, v1[24:0], v2[7:0]);
            "R", "W": begin
               exp_req = sdram_req_t'{addr: v4[24:0], we: v5[0], wdata: v3[7:0]};
               cpu_access(name, op == "W", v1[15:0], v2[3:0], v3[7:0], exp_req, v6[7:0]);
            end
            "M": apply_status(name, v1[7:0]);
            "S": pulse_reset_source(name, int'(v1));
            "A": check_autoboot(name);
            default: stop_on_error($sformatf("%s is not a known operation", name));
         endcase
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/bbc_mem_input.txt
# R/W: op cpu_addr romsel wdata exp_sdram_addr exp_we exp_mem_di
# L: op loader_addr data | M: op status_byte | S: op reset_source (0-5) | A: autoboot check
L 1000123 3C
L 1004010 B7
L 1008200 D2
L 100C010 EE
L 0068345 77
R C123 0 00 0040123 0 3C
R 8010 E 00 0078010 0 B7
R 8200 C 00 0070200 0 D2
R 8345 A 00 0068345 0 77
W 1234 0 5A 0001234 1 5A
R 1234 0 00 0001234 0 5A
W 9000 5 A5 0055000 1 A5
R 9000 5 00 0055000 0 A5
W BFFF 7 3E 005FFFF 1 3E
R BFFF 7 00 005FFFF 0 3E
W 8010 E 99 0078010 0 B7
R 8000 3 00 004C000 0 FF
M 04
R 8010 E 00 0078010 0 FF
R 8010 0 00 0040010 0 B7
R 8200 2 00 0048200 0 D2
R 8200 C 00 0070200 0 FF
S 0
S 1
S 2
S 3
S 4
S 5
M 0C
A

//--- compile.f
common/mem_map_pkg.sv
common/core_ctrl_pkg.sv
mem_map/mem_map_decode.sv
mem_map/rom_slot.sv
mem_map/read_data_select.sv
src/reset_control.sv
src/bbc_mem_subsystem.sv
test/tb_bbc_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f \
   --top-module tb_bbc_mem_subsystem -o sim_bbc_mem > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_bbc_mem > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
